// File: hdl/backend_pkg.sv
package backend_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN   = 32;
    localparam int REG_AW = 4;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_ADDI  = 4'd6,
        OP_LD    = 4'd7,
        OP_ST    = 4'd8,
        OP_RDCNT = 4'd9
    } opcode_e;

    // Fault codes carried with a load or store to commit.
    typedef enum logic [1:0] {
        EXC_NONE  = 2'd0,
        EXC_ALIGN = 2'd1,
        EXC_RANGE = 2'd2
    } excp_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   mem_addr;
        logic [XLEN-1:0]   st_data;
    } ex2mem_t;

    // For LD the wdata field holds the load data.
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        opcode_e           op;
        excp_e             excp;
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
        logic              st_en;
        logic [XLEN-1:0]   st_addr;
        logic [XLEN-1:0]   st_data;
    } mem2wb_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        opcode_e           op;
        excp_e             excp;
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
        logic              st_en;
        logic [XLEN-1:0]   st_addr;
        logic [XLEN-1:0]   st_data;
    } commit_t;

endpackage

// File: hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               advance_i,
    input  logic                               flush_i,
    input  backend_pkg::issue_t                issue_i,
    input  logic [backend_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [backend_pkg::XLEN-1:0]       rs2_data_i,
    input  backend_pkg::fwd_t                  fwd_wb_i,
    input  backend_pkg::commit_t               commit_i,
    output logic [backend_pkg::REG_AW-1:0]     rs1_addr_o,
    output logic [backend_pkg::REG_AW-1:0]     rs2_addr_o,
    output backend_pkg::ex2mem_t               ex2mem_o
);

    backend_pkg::issue_t              issue_q;
    logic [backend_pkg::XLEN-1:0]     instr_cnt;
    logic [backend_pkg::XLEN-1:0]     op_a;
    logic [backend_pkg::XLEN-1:0]     op_b;
    logic [backend_pkg::XLEN-1:0]     alu_res;
    logic                             writes_reg;

    // The younger stage wins, r0 is never bypassed.
    function automatic logic [backend_pkg::XLEN-1:0] resolve(
        input logic [backend_pkg::REG_AW-1:0] addr,
        input logic [backend_pkg::XLEN-1:0]   rf_data,
        input backend_pkg::fwd_t              fwd,
        input backend_pkg::commit_t           cmt
    );
        logic [backend_pkg::XLEN-1:0] value;
        value = rf_data;
        if (addr != '0) begin
            if (fwd.we && fwd.waddr == addr) begin
                value = fwd.wdata;
            end else if (cmt.valid && cmt.we && cmt.waddr == addr) begin
                value = cmt.wdata;
            end
        end
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue register and instruction counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_q <= '0;
        end else if (flush_i) begin
            issue_q <= '0;
        end else if (advance_i) begin
            issue_q <= issue_i;
        end
    end

    // Dropped instructions still count, they were accepted.
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_cnt <= '0;
        end else if (advance_i && issue_i.valid) begin
            instr_cnt <= instr_cnt + backend_pkg::XLEN'(1);
        end
    end

    assign rs1_addr_o = issue_q.rs1;
    assign rs2_addr_o = issue_q.rs2;

    assign op_a = resolve(issue_q.rs1, rs1_data_i, fwd_wb_i, commit_i);
    assign op_b = resolve(issue_q.rs2, rs2_data_i, fwd_wb_i, commit_i);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_res    = '0;
        writes_reg = 1'b1;
        case (issue_q.op)
            backend_pkg::OP_ADD:   alu_res = op_a + op_b;
            backend_pkg::OP_SUB:   alu_res = op_a - op_b;
            backend_pkg::OP_AND:   alu_res = op_a & op_b;
            backend_pkg::OP_OR:    alu_res = op_a | op_b;
            backend_pkg::OP_XOR:   alu_res = op_a ^ op_b;
            backend_pkg::OP_ADDI:  alu_res = op_a + issue_q.imm;
            backend_pkg::OP_LD:    alu_res = '0;
            // The counter already includes this RDCNT itself.
            backend_pkg::OP_RDCNT: alu_res = instr_cnt - backend_pkg::XLEN'(1);
            default:               writes_reg = 1'b0;
        endcase
    end

    always_comb begin
        ex2mem_o.valid    = issue_q.valid;
        ex2mem_o.pc       = issue_q.pc;
        ex2mem_o.op       = issue_q.op;
        ex2mem_o.rd       = issue_q.rd;
        ex2mem_o.we       = issue_q.valid & writes_reg;
        ex2mem_o.result   = alu_res;
        ex2mem_o.mem_addr = op_a + issue_q.imm;
        ex2mem_o.st_data  = op_b;
    end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance_i,
    input  logic                  flush_i,
    input  backend_pkg::ex2mem_t  ex2mem_i,
    input  logic                  store_commit_i,
    output backend_pkg::mem2wb_t  mem2wb_o
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    backend_pkg::ex2mem_t            ex_q;
    logic [backend_pkg::XLEN-1:0]    dmem [DMEM_WORDS];
    logic                            is_ld;
    logic                            is_st;
    logic                            bad_align;
    logic                            bad_range;
    backend_pkg::excp_e              excp;
    logic [IDX_W-1:0]                ld_idx;
    logic [IDX_W-1:0]                st_idx;
    logic [backend_pkg::XLEN-1:0]    ld_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else if (flush_i) begin
            ex_q <= '0;
        end else if (advance_i) begin
            ex_q <= ex2mem_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_ld     = ex_q.valid && ex_q.op == backend_pkg::OP_LD;
    assign is_st     = ex_q.valid && ex_q.op == backend_pkg::OP_ST;
    assign bad_align = ex_q.mem_addr[1:0] != 2'b00;
    assign bad_range =
        ex_q.mem_addr[backend_pkg::XLEN-1:2] >= (backend_pkg::XLEN-2)'(DMEM_WORDS);

    // Alignment is reported ahead of range.
    always_comb begin
        excp = backend_pkg::EXC_NONE;
        if (is_ld || is_st) begin
            if (bad_align) begin
                excp = backend_pkg::EXC_ALIGN;
            end else if (bad_range) begin
                excp = backend_pkg::EXC_RANGE;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ld_idx  = ex_q.mem_addr[IDX_W+1:2];
    assign st_idx  = mem2wb_o.st_addr[IDX_W+1:2];
    assign ld_data = (is_ld && excp == backend_pkg::EXC_NONE) ? dmem[ld_idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_commit_i) begin
            dmem[st_idx] <= mem2wb_o.st_data;
        end
    end

    always_comb begin
        mem2wb_o.valid   = ex_q.valid;
        mem2wb_o.pc      = ex_q.pc;
        mem2wb_o.op      = ex_q.op;
        mem2wb_o.excp    = excp;
        mem2wb_o.we      = ex_q.we && excp == backend_pkg::EXC_NONE;
        mem2wb_o.waddr   = ex_q.rd;
        mem2wb_o.wdata   = is_ld ? ld_data : ex_q.result;
        mem2wb_o.st_en   = is_st && excp == backend_pkg::EXC_NONE;
        mem2wb_o.st_addr = ex_q.mem_addr;
        mem2wb_o.st_data = ex_q.st_data;
    end

endmodule

// File: hdl/pipe_backend.sv
`timescale 1ns/1ps

module pipe_backend #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance_i,
    input  backend_pkg::issue_t   issue_i,
    output backend_pkg::commit_t  commit_o,
    output logic                  flush_o
);

    backend_pkg::ex2mem_t            ex2mem;
    backend_pkg::mem2wb_t            mem2wb;
    backend_pkg::commit_t            commit;
    backend_pkg::fwd_t               fwd_wb;
    logic                            flush;
    logic                            store_commit;
    logic [backend_pkg::REG_AW-1:0]  rs1_addr;
    logic [backend_pkg::REG_AW-1:0]  rs2_addr;
    logic [backend_pkg::XLEN-1:0]    rs1_data;
    logic [backend_pkg::XLEN-1:0]    rs2_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    exec_stage exec_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .advance_i  (advance_i),
        .flush_i    (flush),
        .issue_i    (issue_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fwd_wb_i   (fwd_wb),
        .commit_i   (commit),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .ex2mem_o   (ex2mem)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .advance_i      (advance_i),
        .flush_i        (flush),
        .ex2mem_i       (ex2mem),
        .store_commit_i (store_commit),
        .mem2wb_o       (mem2wb)
    );

    wb_stage wb_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .advance_i      (advance_i),
        .mem_i          (mem2wb),
        .commit_o       (commit),
        .fwd_o          (fwd_wb),
        .flush_o        (flush),
        .store_commit_o (store_commit)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .commit_i   (commit),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign commit_o = commit;
    assign flush_o  = flush;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             rst,
    input  backend_pkg::commit_t             commit_i,
    input  logic [backend_pkg::REG_AW-1:0]   rs1_addr_i,
    input  logic [backend_pkg::REG_AW-1:0]   rs2_addr_i,
    output logic [backend_pkg::XLEN-1:0]     rs1_data_o,
    output logic [backend_pkg::XLEN-1:0]     rs2_data_o
);

    localparam int NREGS = 1 << backend_pkg::REG_AW;

    logic [backend_pkg::XLEN-1:0] regs [NREGS];
    logic                         wr_en;

    assign wr_en = commit_i.valid && commit_i.we && commit_i.waddr != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[commit_i.waddr] <= commit_i.wdata;
        end
    end

    // r0 is hard zero.
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance_i,
    input  backend_pkg::mem2wb_t  mem_i,
    output backend_pkg::commit_t  commit_o,
    output backend_pkg::fwd_t     fwd_o,
    output logic                  flush_o,
    output logic                  store_commit_o
);

    logic faulted;

    assign faulted = mem_i.valid && mem_i.excp != backend_pkg::EXC_NONE;

    // Both strobes act at the same edge that moves the instruction to commit.
    assign flush_o        = faulted && advance_i;
    assign store_commit_o = mem_i.valid && mem_i.st_en && !faulted && advance_i;

    // The in-flight result is seen by execute ahead of the commit record.
    assign fwd_o.we    = mem_i.valid && mem_i.we;
    assign fwd_o.waddr = mem_i.waddr;
    assign fwd_o.wdata = mem_i.wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_o <= '0;
        end else if (advance_i) begin
            commit_o.valid   <= mem_i.valid;
            commit_o.pc      <= mem_i.pc;
            commit_o.op      <= mem_i.op;
            commit_o.excp    <= mem_i.excp;
            commit_o.we      <= mem_i.we;
            commit_o.waddr   <= mem_i.waddr;
            commit_o.wdata   <= mem_i.wdata;
            commit_o.st_en   <= mem_i.st_en;
            commit_o.st_addr <= mem_i.st_addr;
            commit_o.st_data <= mem_i.st_data;
        end else begin
            // A stalled cycle shows a bubble, so nothing commits twice.
            commit_o <= '0;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the backend testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module backend_tb \
    --Mdir obj_dir -o backend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/backend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: src.f
hdl/backend_pkg.sv
hdl/reg_file.sv
hdl/exec_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/pipe_backend.sv
+incdir+test
test/backend_tb.sv

// File: test/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// Each entry is one issued instruction; pc is four times the table index.
localparam int PROG_LEN = 30;

backend_pkg::issue_t  prog [PROG_LEN];
backend_pkg::commit_t exp_q [$];
int                   exp_flushes;

function automatic backend_pkg::issue_t make_instr(
    input int                  idx,
    input backend_pkg::opcode_e op,
    input int                  rd,
    input int                  rs1,
    input int                  rs2,
    input logic [31:0]         imm
);
    backend_pkg::issue_t ins;
    ins.valid = 1'b1;
    ins.pc    = 32'(idx * 4);
    ins.op    = op;
    ins.rd    = 4'(rd);
    ins.rs1   = 4'(rs1);
    ins.rs2   = 4'(rs2);
    ins.imm   = imm;
    return ins;
endfunction

function automatic void load_program();
    prog[0]  = make_instr(0,  backend_pkg::OP_ADDI,  1,  0,  0, 32'd5);
    prog[1]  = make_instr(1,  backend_pkg::OP_ADDI,  2,  1,  0, 32'd3);
    prog[2]  = make_instr(2,  backend_pkg::OP_ADD,   3,  1,  2, 32'd0);
    prog[3]  = make_instr(3,  backend_pkg::OP_SUB,   4,  3,  1, 32'd0);
    prog[4]  = make_instr(4,  backend_pkg::OP_XOR,   5,  4,  2, 32'd0);
    prog[5]  = make_instr(5,  backend_pkg::OP_OR,    6,  3,  4, 32'd0);
    prog[6]  = make_instr(6,  backend_pkg::OP_AND,   7,  6,  2, 32'd0);
    prog[7]  = make_instr(7,  backend_pkg::OP_ADDI,  0,  1,  0, 32'd7);
    prog[8]  = make_instr(8,  backend_pkg::OP_ADD,   8,  0,  1, 32'd0);
    prog[9]  = make_instr(9,  backend_pkg::OP_ST,    0,  0,  3, 32'd16);
    prog[10] = make_instr(10, backend_pkg::OP_LD,    9,  0,  0, 32'd16);
    prog[11] = make_instr(11, backend_pkg::OP_ADDI,  10, 9,  0, 32'd1);
    prog[12] = make_instr(12, backend_pkg::OP_ST,    0,  0,  2, 32'd18);
    prog[13] = make_instr(13, backend_pkg::OP_ADDI,  11, 0,  0, 32'd99);
    prog[14] = make_instr(14, backend_pkg::OP_ADDI,  12, 0,  0, 32'd77);
    prog[15] = make_instr(15, backend_pkg::OP_LD,    13, 0,  0, 32'd16);
    prog[16] = make_instr(16, backend_pkg::OP_LD,    14, 0,  0, 32'd256);
    prog[17] = make_instr(17, backend_pkg::OP_ADDI,  11, 0,  0, 32'd1);
    prog[18] = make_instr(18, backend_pkg::OP_ADDI,  12, 0,  0, 32'd2);
    prog[19] = make_instr(19, backend_pkg::OP_ADD,   15, 11, 12, 32'd0);
    prog[20] = make_instr(20, backend_pkg::OP_ST,    0,  1,  8, 32'd251);
    prog[21] = make_instr(21, backend_pkg::OP_NOP,   0,  0,  0, 32'd0);
    prog[22] = make_instr(22, backend_pkg::OP_NOP,   0,  0,  0, 32'd0);
    prog[23] = make_instr(23, backend_pkg::OP_LD,    13, 0,  0, 32'd0);
    prog[24] = make_instr(24, backend_pkg::OP_RDCNT, 1,  0,  0, 32'd0);
    prog[25] = make_instr(25, backend_pkg::OP_ADDI,  2,  1,  0, 32'd1);
    prog[26] = make_instr(26, backend_pkg::OP_ST,    0,  0,  2, 32'd252);
    prog[27] = make_instr(27, backend_pkg::OP_LD,    3,  0,  0, 32'd252);
    prog[28] = make_instr(28, backend_pkg::OP_RDCNT, 4,  0,  0, 32'd0);
    prog[29] = make_instr(29, backend_pkg::OP_NOP,   0,  0,  0, 32'd0);
endfunction

// Walks the table in order and queues the commits that must appear.
function automatic void fill_expected();
    logic [31:0]          regs [16];
    logic [31:0]          mem [DMEM_WORDS];
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          addr;
    int                   skip;
    int                   widx;
    backend_pkg::commit_t c;
    exp_q.delete();
    exp_flushes = 0;
    skip = 0;
    for (int r = 0; r < 16; r++) begin
        regs[r] = '0;
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
        mem[w] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
        if (skip > 0) begin
            skip--;
            continue;
        end
        a = regs[prog[i].rs1];
        b = regs[prog[i].rs2];
        addr = a + prog[i].imm;
        c = '0;
        c.valid = 1'b1;
        c.pc    = prog[i].pc;
        c.op    = prog[i].op;
        c.excp  = backend_pkg::EXC_NONE;
        c.waddr = prog[i].rd;
        c.we    = 1'b1;
        case (prog[i].op)
            backend_pkg::OP_ADD:   c.wdata = a + b;
            backend_pkg::OP_SUB:   c.wdata = a - b;
            backend_pkg::OP_AND:   c.wdata = a & b;
            backend_pkg::OP_OR:    c.wdata = a | b;
            backend_pkg::OP_XOR:   c.wdata = a ^ b;
            backend_pkg::OP_ADDI:  c.wdata = a + prog[i].imm;
            backend_pkg::OP_RDCNT: c.wdata = 32'(i);
            backend_pkg::OP_LD, backend_pkg::OP_ST: begin
                c.we = 1'b0;
                if (addr[1:0] != 2'b00) begin
                    c.excp = backend_pkg::EXC_ALIGN;
                end else if ((addr >> 2) >= 32'(DMEM_WORDS)) begin
                    c.excp = backend_pkg::EXC_RANGE;
                end
                widx = int'(addr >> 2);
                if (c.excp != backend_pkg::EXC_NONE) begin
                    skip = 2;
                    exp_flushes++;
                end else if (prog[i].op == backend_pkg::OP_LD) begin
                    c.we    = 1'b1;
                    c.wdata = mem[widx];
                end else begin
                    c.st_en   = 1'b1;
                    c.st_addr = addr;
                    c.st_data = b;
                    mem[widx] = b;
                end
            end
            default: c.we = 1'b0;
        endcase
        if (c.we && prog[i].rd != 4'd0) begin
            regs[prog[i].rd] = c.wdata;
        end
        exp_q.push_back(c);
    end
endfunction

`endif

// File: test/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    localparam int DMEM_WORDS      = 64;
    localparam int RESET_CYCLES    = 8;
    localparam int CLK_HALF        = 10;

    logic                 clk;
    logic                 rst;
    logic                 advance_i;
    backend_pkg::issue_t  issue_i;
    backend_pkg::commit_t commit_o;
    logic                 flush_o;

    int          errors;
    int          checks;
    int          pass_num;
    int          flush_seen;
    int          adv_edges;
    logic [31:0] lcg_state;

    `include "backend_model.svh"

    localparam int WATCHDOG_CYCLES = 2 * (2 * PROG_LEN * 4 + RESET_CYCLES + 4);

    pipe_backend #(
        .DMEM_WORDS (DMEM_WORDS)
    ) pipe_backend_inst (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance_i),
        .issue_i   (issue_i),
        .commit_o  (commit_o),
        .flush_o   (flush_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input logic [backend_pkg::XLEN-1:0] exp,
                              input logic [backend_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_excp(input string name, input backend_pkg::excp_e exp,
                              input backend_pkg::excp_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_op(input string name, input backend_pkg::opcode_e exp,
                            input backend_pkg::opcode_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Roughly one cycle in four is a stall.
    function automatic logic pick_advance();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[31:30] != 2'b00;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            adv_edges <= 0;
        end else if (advance_i) begin
            adv_edges <= adv_edges + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        backend_pkg::commit_t e;
        string                name;
        if (!rst) begin
            if ((commit_o.valid || flush_o) && adv_edges < 3) begin
                errors++;
                $display("Commit or flush seen before three advancing edges after reset");
            end
            if (flush_o) begin
                flush_seen++;
            end
            if (commit_o.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected extra commit at pc %08h in pass %0d",
                             commit_o.pc, pass_num);
                end else begin
                    e = exp_q.pop_front();
                    name = $sformatf("pass %0d pc %08h", pass_num, e.pc);
                    check_word({name, " pc"}, e.pc, commit_o.pc);
                    check_op({name, " op"}, e.op, commit_o.op);
                    check_excp({name, " excp"}, e.excp, commit_o.excp);
                    check_word({name, " we"}, 32'(e.we), 32'(commit_o.we));
                    if (e.we) begin
                        check_word({name, " waddr"}, 32'(e.waddr), 32'(commit_o.waddr));
                        check_word({name, " wdata"}, e.wdata, commit_o.wdata);
                    end
                    check_word({name, " st_en"}, 32'(e.st_en), 32'(commit_o.st_en));
                    if (e.st_en) begin
                        check_word({name, " st_addr"}, e.st_addr, commit_o.st_addr);
                        check_word({name, " st_data"}, e.st_data, commit_o.st_data);
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apply_reset();
        rst       = 1'b1;
        advance_i = 1'b0;
        issue_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic run_pass(input logic stall);
        int idx;
        idx = 0;
        while (idx < PROG_LEN) begin
            @(posedge clk);
            #2;
            advance_i = stall ? pick_advance() : 1'b1;
            issue_i   = prog[idx];
            if (advance_i) begin
                idx++;
            end
        end
        // Drain with bubbles until every expected commit has been seen.
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #2;
            issue_i   = '0;
            advance_i = stall ? pick_advance() : 1'b1;
        end
        @(posedge clk);
        #2;
        advance_i = 1'b1;
        repeat (4) @(posedge clk);
        #2;
    endtask

    initial begin
        rst       = 1'b1;
        advance_i = 1'b0;
        issue_i   = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h2096;
        load_program();
        for (pass_num = 1; pass_num <= 2; pass_num++) begin
            fill_expected();
            flush_seen = 0;
            apply_reset();
            run_pass(pass_num == 2);
            check_word($sformatf("pass %0d flush count", pass_num),
                       32'(exp_flushes), 32'(flush_seen));
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Both passes must finish well inside this bound.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, %0d commits still missing in pass %0d", exp_q.size(), pass_num);
        $display("tests failed");
        $finish;
    end

endmodule
